//--- Bender.yml
package:
  name: eg_top

sources:
  - hdl/eg_types_pkg.sv
  - hdl/slot_timing_pkg.sv
  - hdl/eg_counter.sv
  - hdl/eg_slot_state.sv
  - hdl/eg_rate.sv
  - hdl/eg_level.sv
  - hdl/eg_output.sv
  - hdl/eg_top.sv
  - target: test
    include_dirs:
      - tests
    files:
      - tests/tb_eg_top.sv

//--- eg_top.f
+incdir+tests
hdl/eg_types_pkg.sv
hdl/slot_timing_pkg.sv
hdl/eg_counter.sv
hdl/eg_slot_state.sv
hdl/eg_rate.sv
hdl/eg_level.sv
hdl/eg_output.sv
hdl/eg_top.sv
tests/tb_eg_top.sv

//--- hdl/eg_counter.sv
// global envelope counter and its divide by three prescaler
`timescale 1ns/10ps
`default_nettype none

module eg_counter import slot_timing_pkg::*; (
	input  logic                clk,
	input  logic                rst,
	input  logic                clk_en,
	input  logic                zero,    // slot 0 strobe
	output logic [EG_CNT_W-1:0] eg_cnt
);

	logic [$clog2(PRESCALE)-1:0] presc; // zero strobes seen since last step

	always_ff @(posedge clk) begin
		if (rst) begin
			presc  <= '0;
			eg_cnt <= '0;
		end else if (clk_en && zero) begin
			if (presc == PRESCALE - 1) begin // one full prescale period
				presc  <= '0;
				eg_cnt <= eg_cnt + 1'b1; // free running, wraps
			end else begin
				presc <= presc + 1'b1;
			end
		end
	end

	// prescaler stays inside its modulo range across every round
	a_presc_range: assert property (@(posedge clk) disable iff (rst)
		presc <= PRESCALE - 1);

endmodule

`default_nettype wire

//--- hdl/eg_level.sv
// attack and decay level arithmetic with saturation
`timescale 1ns/10ps
`default_nettype none

module eg_level import eg_types_pkg::*; (
	input  logic      clk,
	input  logic      rst,
	input  logic      clk_en,
	input  eg_slot_t  slot_vi,
	input  eg_rate_t  rate_vi,
	input  logic      step_vi,
	input  logic      sum_up_vi,
	output eg_level_t level_vii,
	output eg_phase_t phase_vii
);

	logic [3:0]  dec_step; // 1 to 8 per update
	logic [10:0] dec_sum;  // one spare bit for saturation
	logic [8:0]  ar_sum0;
	logic [9:0]  ar_sum;
	eg_level_t   ar_result;
	logic        instant;

	// decay increment by rate group
	always_comb begin
		case (rate_vi[5:2])
			4'd12:   dec_step = {2'b0, step_vi, ~step_vi};
			4'd13:   dec_step = {1'b0, step_vi, ~step_vi, 1'b0};
			4'd14:   dec_step = {step_vi, ~step_vi, 2'b0};
			4'd15:   dec_step = 4'd8;
			default: dec_step = {2'b0, step_vi, 1'b0};
		endcase
		dec_sum = {1'b0, slot_vi.level} + {7'd0, dec_step};
	end

	// attack, exponential approach to 0
	always_comb begin
		case (rate_vi[5:2])
			4'd13:        ar_sum0 = {1'b0, slot_vi.level[9:3]} + 9'd1;
			4'd14, 4'd15: ar_sum0 = {1'b0, slot_vi.level[9:2]} + 9'd1;
			default:      ar_sum0 = {3'd0, slot_vi.level[9:4]} + 9'd1;
		endcase
		if (rate_vi[5:4] == 2'b11)
			ar_sum = step_vi ? {ar_sum0, 1'b0} : {1'b0, ar_sum0}; // doubled on step
		else
			ar_sum = step_vi ? {1'b0, ar_sum0} : 10'd0;
		ar_result = (ar_sum < slot_vi.level) ? slot_vi.level - ar_sum : '0; // floor at 0
		instant   = (slot_vi.phase == ATTACK) && (slot_vi.cfg == 5'd31);
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			level_vii <= EG_MAX;
			phase_vii <= RELEASE;
		end else if (clk_en) begin
			phase_vii <= slot_vi.phase;
			if (instant)
				level_vii <= '0; // arate 31
			else if (slot_vi.phase == ATTACK) begin
				if (sum_up_vi && slot_vi.level != '0)
					level_vii <= (rate_vi[5:1] == 5'h1f) ? '0 : ar_result;
				else
					level_vii <= slot_vi.level;
			end else if (sum_up_vi)
				level_vii <= dec_sum[10] ? EG_MAX : dec_sum[9:0]; // saturate
			else
				level_vii <= slot_vi.level;
		end
	end

	// level fed in by the rate stages never grows while attacking
	a_attack_down: assert property (@(posedge clk) disable iff (rst)
		clk_en && slot_vi.phase == ATTACK |=> level_vii <= $past(slot_vi.level));

endmodule

`default_nettype wire

//--- hdl/eg_output.sv
// total level addition, clamping and the output register
`timescale 1ns/10ps
`default_nettype none

module eg_output import eg_types_pkg::*; (
	input  logic       clk,
	input  logic       rst,
	input  logic       clk_en,
	input  eg_level_t  level_vii,
	input  logic [6:0] tl,       // total level, 0.75 dB steps
	output eg_level_t  eg_out    // stage VIII
);

	logic [10:0] tl_sum; // worst case 1023 + 1016 fits

	// tl lsb is 8 level lsbs
	assign tl_sum = {1'b0, level_vii} + {1'b0, tl, 3'b000};

	always_ff @(posedge clk) begin
		if (rst)
			eg_out <= EG_MAX;
		else if (clk_en)
			eg_out <= tl_sum[10] ? EG_MAX : tl_sum[9:0]; // clamp to silent
	end

endmodule

`default_nettype wire

//--- hdl/eg_rate.sv
// key scaled rate, envelope counter bit selection and step decision
`timescale 1ns/10ps
`default_nettype none

module eg_rate import eg_types_pkg::*, slot_timing_pkg::*; (
	input  logic                clk,
	input  logic                rst,
	input  logic                clk_en,
	input  eg_slot_t            slot_iii,
	input  logic [4:0]          keycode, // stage III
	input  logic [1:0]          ks,      // key scale, stage III
	input  logic [EG_CNT_W-1:0] eg_cnt,
	output eg_slot_t            slot_vi,
	output eg_rate_t            rate_vi,
	output logic                step_vi,
	output logic                sum_up_vi // counter bit toggled since last round
);

	logic [6:0] pre_rate;
	eg_rate_t   rate_iii;
	eg_rate_t   rate_iv, rate_v;
	eg_slot_t   slot_iv, slot_v;
	logic [3:0] cnt_lsb;
	logic [2:0] cnt_v;
	logic [NUM_SLOTS-1:0] cnt_hist; // low counter bit, one round back
	logic [7:0] step_idx;
	logic       step_v;

	//////////////////////////////////////////////////
	// stage III, key scaling
	always_comb begin
		pre_rate = {1'b0, slot_iii.cfg, 1'b0} + 7'(keycode >> (2'd3 - ks));
		if (slot_iii.cfg == '0)
			rate_iii = '0; // rate 0 stays still whatever the key
		else
			rate_iii = pre_rate[6] ? 6'd63 : pre_rate[5:0]; // clamp
	end

	// stage IV, faster groups look at lower counter bits
	always_comb begin
		if (slot_iv.phase == ATTACK) // attack runs one bit lower
			cnt_lsb = (rate_iv[5:2] >= 4'd11) ? 4'd0 : 4'd11 - rate_iv[5:2];
		else
			cnt_lsb = (rate_iv[5:2] >= 4'd12) ? 4'd0 : 4'd12 - rate_iv[5:2];
	end

	//////////////////////////////////////////////////
	// stage V, step pattern
	always_comb begin
		if (rate_v[5:4] == 2'b11) begin
			if (rate_v[5:2] == 4'hf && slot_v.phase == ATTACK)
				step_idx = 8'b1111_1111; // 60 and up, attack every time
			else
				case (rate_v[1:0])
					2'd0:    step_idx = 8'b0000_0000;
					2'd1:    step_idx = 8'b1000_1000;
					2'd2:    step_idx = 8'b1010_1010;
					default: step_idx = 8'b1110_1110;
				endcase
		end else begin
			if (rate_v[5:2] == 4'd0 && slot_v.phase != ATTACK)
				step_idx = 8'b1111_1110; // slowest decay group, 7 of 8
			else
				case (rate_v[1:0])
					2'd0:    step_idx = 8'b1010_1010; // 4 of 8
					2'd1:    step_idx = 8'b1110_1010;
					2'd2:    step_idx = 8'b1110_1110;
					default: step_idx = 8'b1111_1110;
				endcase
		end
		step_v = (rate_v[5:1] == 5'd0) ? 1'b0 : step_idx[cnt_v]; // rate 0/1 frozen
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			rate_iv   <= '0;
			slot_iv   <= EG_SLOT_IDLE;
			rate_v    <= '0;
			slot_v    <= EG_SLOT_IDLE;
			cnt_v     <= '0;
			cnt_hist  <= '0;
			rate_vi   <= '0;
			slot_vi   <= EG_SLOT_IDLE;
			step_vi   <= 1'b0;
			sum_up_vi <= 1'b0;
		end else if (clk_en) begin
			rate_iv   <= rate_iii; // III -> IV
			slot_iv   <= slot_iii;
			rate_v    <= rate_iv;  // IV -> V
			slot_v    <= slot_iv;
			cnt_v     <= 3'(eg_cnt >> cnt_lsb);
			cnt_hist  <= {cnt_hist[NUM_SLOTS-2:0], cnt_v[0]};
			rate_vi   <= rate_v;   // V -> VI
			slot_vi   <= slot_v;
			step_vi   <= step_v;
			sum_up_vi <= cnt_v[0] != cnt_hist[NUM_SLOTS-1];
		end
	end

endmodule

`default_nettype wire

//--- hdl/eg_slot_state.sv
// key edge detection, phase selection, level/phase/key-on recirculation rings
`timescale 1ns/10ps
`default_nettype none

module eg_slot_state import eg_types_pkg::*, slot_timing_pkg::*; (
	input  logic      clk,
	input  logic      rst,
	input  logic      clk_en,
	input  logic      keyon,     // level, stage II
	input  eg_rates_t rates,     // stage II
	input  eg_level_t level_vii, // from level arithmetic
	input  eg_phase_t phase_vii,
	output eg_slot_t  slot_iii,
	output logic      pg_rst     // phase generator reset
);

	eg_level_t level_ring [LEVEL_RING_DEPTH];
	eg_phase_t phase_ring [LEVEL_RING_DEPTH];
	logic [NUM_SLOTS-1:0] keyon_hist; // one full round of key-on levels

	eg_level_t level_ii;
	eg_phase_t phase_ii;
	logic      keyon_last;
	logic      keyon_now;
	logic      keyoff_now;
	logic [4:0] d1_level;
	eg_slot_t  next_slot;
	logic      next_pg_rst;

	//////////////////////////////////////////////////
	// recirculation, VII back round to II
	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < LEVEL_RING_DEPTH; i++) begin
				level_ring[i] <= EG_MAX; // every slot starts silent
				phase_ring[i] <= RELEASE;
			end
			keyon_hist <= '0;
		end else if (clk_en) begin
			level_ring[0] <= level_vii;
			phase_ring[0] <= phase_vii;
			for (int i = 1; i < LEVEL_RING_DEPTH; i++) begin
				level_ring[i] <= level_ring[i-1];
				phase_ring[i] <= phase_ring[i-1];
			end
			keyon_hist <= {keyon_hist[NUM_SLOTS-2:0], keyon};
		end
	end

	assign level_ii   = level_ring[LEVEL_RING_DEPTH-1];
	assign phase_ii   = phase_ring[LEVEL_RING_DEPTH-1];
	assign keyon_last = keyon_hist[NUM_SLOTS-1]; // same slot, previous round

	//////////////////////////////////////////////////
	// stage II phase selection
	always_comb begin
		keyon_now  = keyon & ~keyon_last;
		keyoff_now = ~keyon & keyon_last;
		d1_level   = (rates.d1l == 4'd15) ? 5'h1f : {1'b0, rates.d1l}; // 15 means bottom
		next_slot.level = level_ii; // level itself only changes at VI
		next_pg_rst     = keyon_now || (level_ii == EG_MAX);
		if (keyoff_now) begin
			next_slot.phase = RELEASE;
			next_slot.cfg   = {rates.rrate, 1'b1}; // release rate is 4 bits, odd
		end else if (keyon_now) begin
			next_slot.phase = ATTACK;
			next_slot.cfg   = rates.arate; // 31 here means instant attack
		end else begin
			unique case (phase_ii)
				ATTACK: begin
					if (level_ii == '0) begin // peak reached
						next_slot.phase = DECAY1;
						next_slot.cfg   = rates.rate1;
					end else begin
						next_slot.phase = ATTACK;
						next_slot.cfg   = rates.arate;
					end
				end
				DECAY1: begin
					if (level_ii[9:5] >= d1_level) begin // sustain level hit
						next_slot.phase = DECAY2;
						next_slot.cfg   = rates.rate2;
					end else begin
						next_slot.phase = DECAY1;
						next_slot.cfg   = rates.rate1;
					end
				end
				DECAY2: begin
					next_slot.phase = DECAY2;
					next_slot.cfg   = rates.rate2;
				end
				default: begin // release, holds until next key-on
					next_slot.phase = RELEASE;
					next_slot.cfg   = {rates.rrate, 1'b1};
				end
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			slot_iii <= EG_SLOT_IDLE;
			pg_rst   <= 1'b0;
		end else if (clk_en) begin
			slot_iii <= next_slot;
			pg_rst   <= next_pg_rst;
		end
	end

	// whatever the level stage writes must come back as a legal phase
	a_phase_legal: assert property (@(posedge clk) disable iff (rst)
		phase_ii inside {ATTACK, DECAY1, DECAY2, RELEASE});

endmodule

`default_nettype wire

//--- hdl/eg_top.sv
// envelope generator top, counter, slot state, rate, level and output stages
`timescale 1ns/10ps
`default_nettype none

module eg_top import eg_types_pkg::*, slot_timing_pkg::*; (
	input  logic       clk,
	input  logic       rst,
	input  logic       clk_en,
	input  logic       zero,    // slot 0 marker
	input  logic       keyon,   // stage II
	input  eg_rates_t  rates,   // stage II
	input  logic [4:0] keycode, // stage III
	input  logic [1:0] ks,      // stage III
	input  logic [6:0] tl,      // stage VII
	output eg_level_t  eg_out,  // stage VIII
	output logic       pg_rst
);

	logic [EG_CNT_W-1:0] eg_cnt;
	eg_slot_t  slot_iii, slot_vi;
	eg_rate_t  rate_vi;
	logic      step_vi, sum_up_vi;
	eg_level_t level_vii;
	eg_phase_t phase_vii;

	//////////////////////////////////////////////////
	// input side
	eg_counter u_counter (
		.clk(clk), .rst(rst), .clk_en(clk_en), .zero(zero),
		.eg_cnt(eg_cnt)
	);

	eg_slot_state u_slot_state (
		.clk(clk), .rst(rst), .clk_en(clk_en),
		.keyon(keyon), .rates(rates),
		.level_vii(level_vii), .phase_vii(phase_vii), // loop back from VII
		.slot_iii(slot_iii), .pg_rst(pg_rst)
	);

	//////////////////////////////////////////////////
	// processing, III to VII
	eg_rate u_rate (
		.clk(clk), .rst(rst), .clk_en(clk_en),
		.slot_iii(slot_iii), .keycode(keycode), .ks(ks), .eg_cnt(eg_cnt),
		.slot_vi(slot_vi), .rate_vi(rate_vi),
		.step_vi(step_vi), .sum_up_vi(sum_up_vi)
	);

	eg_level u_level (
		.clk(clk), .rst(rst), .clk_en(clk_en),
		.slot_vi(slot_vi), .rate_vi(rate_vi),
		.step_vi(step_vi), .sum_up_vi(sum_up_vi),
		.level_vii(level_vii), .phase_vii(phase_vii)
	);

	// output side
	eg_output u_output (
		.clk(clk), .rst(rst), .clk_en(clk_en),
		.level_vii(level_vii), .tl(tl),
		.eg_out(eg_out)
	);

endmodule

`default_nettype wire

//--- hdl/eg_types_pkg.sv
// envelope phase enum, level, rate and rate configuration types, level constants
`default_nettype none

package eg_types_pkg;

	// phase codes, release sits at 7 so an idle slot reads all ones
	typedef enum logic [2:0] {
		ATTACK  = 3'd0,
		DECAY1  = 3'd1,
		DECAY2  = 3'd2,
		RELEASE = 3'd7
	} eg_phase_t;

	typedef logic [9:0] eg_level_t; // attenuation, 0 loudest, ~0.094 dB per lsb
	typedef logic [5:0] eg_rate_t;  // key scaled rate
	typedef logic [4:0] eg_cfg_t;   // rate before key scaling

	localparam eg_level_t EG_MAX = 10'h3ff; // silent

	// per slot register values, arrive at stage II
	typedef struct packed {
		logic [4:0] arate; // attack
		logic [4:0] rate1; // first decay
		logic [4:0] rate2; // second decay
		logic [3:0] rrate; // release
		logic [3:0] d1l;   // sustain level
	} eg_rates_t;

	// slot word flowing down the pipeline
	typedef struct packed {
		eg_phase_t phase;
		eg_level_t level;
		eg_cfg_t   cfg;
	} eg_slot_t;

	localparam eg_slot_t EG_SLOT_IDLE = '{phase: RELEASE, level: EG_MAX, cfg: 5'd0};

endpackage

`default_nettype wire

//--- hdl/slot_timing_pkg.sv
// slot count, recirculation depths, envelope counter width and prescale
`default_nettype none

package slot_timing_pkg;

	localparam int NUM_SLOTS        = 24; // 6 channels x 4 operators
	localparam int PIPE_DEPTH       = 5;  // stages II to VII
	localparam int LEVEL_RING_DEPTH = 19; // VII back round to II

	localparam int EG_CNT_W = 15; // global envelope counter
	localparam int PRESCALE = 3;  // zero strobes per counter step

	// slot loop must close on itself
	// a mismatch makes both names share the value 0, which is illegal
	typedef enum int {
		RING_BASE  = 0,
		RING_CLOSE = (PIPE_DEPTH + LEVEL_RING_DEPTH == NUM_SLOTS) ? 1 : 0
	} ring_check_t;

endpackage

`default_nettype wire

//--- tests/tb_eg_checks.svh
// compare tasks and error reporting for the envelope generator testbench
`ifndef TB_EG_CHECKS_SVH
`define TB_EG_CHECKS_SVH

//////////////////////////////////////////////////
// common exit for every failing check
task automatic abort_run;
	$display("tests failed");
	$fatal(1, "run stopped at the first error");
endtask

// failures that have no single expected value
task automatic report_error(input string reason);
	$display("Error at %0t ns: %s", $time, reason);
	abort_run();
endtask

//////////////////////////////////////////////////
// compare tasks, one per result type

// attenuation levels, eg_out and stored slot levels
task automatic check_level(input eg_level_t got, input eg_level_t expected,
		input string what);
	if (got !== expected) begin // x or z counts as wrong too
		$display("Mismatch at %0t ns: %s, got %0d expected %0d",
			$time, what, got, expected);
		abort_run();
	end
endtask

// single bit results such as pg_rst
task automatic check_bit(input logic got, input logic expected, input string what);
	if (got !== expected) begin
		$display("Mismatch at %0t ns: %s, got %b expected %b",
			$time, what, got, expected);
		abort_run();
	end
endtask

`endif

//--- tests/tb_eg_top.sv
// testbench top, clock, slot strobe, LFSR, timeout and directed envelope tests
`timescale 1ns/10ps
`default_nettype none

module tb_eg_top import eg_types_pkg::*, slot_timing_pkg::*; ();

	localparam int RESET_CYCLES  = 16;
	localparam int KEY_WINDOW    = 2 * NUM_SLOTS; // two slot rounds
	localparam int ATTACK_LIMIT  = 3000;          // ~21 attack updates 72 cycles apart
	localparam int SUSTAIN_LIMIT = 3000;          // 24 decay steps of 8
	localparam int RELEASE_LIMIT = 9000;          // ~104 release steps of 8
	localparam int RUN_LIMIT     = 2 * (RESET_CYCLES + 1) + 6 * KEY_WINDOW + ATTACK_LIMIT
		+ SUSTAIN_LIMIT + RELEASE_LIMIT + 16 * NUM_SLOTS + 500; // plus margin

	logic       clk;
	logic       rst;
	logic       clk_en;
	logic       zero;
	logic       keyon;
	eg_rates_t  rates;
	logic [4:0] keycode;
	logic [1:0] ks;
	logic [6:0] tl;
	eg_level_t  eg_out;
	logic       pg_rst;

	int          cycles   = 0; // rising edges so far
	int          slot_cnt = 0; // position in the slot round
	logic [31:0] lfsr;
	eg_level_t   sustain_lvl [NUM_SLOTS]; // per slot sustain level for the tl test

	`include "tb_eg_checks.svh"

	eg_top u_dut (
		.clk(clk), .rst(rst), .clk_en(clk_en), .zero(zero),
		.keyon(keyon), .rates(rates), .keycode(keycode), .ks(ks), .tl(tl),
		.eg_out(eg_out), .pg_rst(pg_rst)
	);

	always #20 clk = ~clk; // 40 ns period

	// slot 0 strobe once per round and the cycle limit
	always @(posedge clk) begin
		cycles   <= cycles + 1;
		slot_cnt <= (slot_cnt == NUM_SLOTS - 1) ? 0 : slot_cnt + 1;
		zero     <= (slot_cnt == NUM_SLOTS - 1);
		if (cycles >= RUN_LIMIT)
			report_error("timeout, the run went past its cycle limit");
	end

	//////////////////////////////////////////////////
	// stimulus helpers

	// fibonacci taps 32 22 2 1
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	task automatic draw_bits(input int n, output logic [6:0] value);
		value = '0;
		for (int i = 0; i < n; i++) begin
			lfsr  = lfsr_step(lfsr); // one step per bit
			value = {value[5:0], lfsr[0]};
		end
	endtask

	// level plus tl x 8 with a ceiling at silent
	function automatic eg_level_t total_level(input eg_level_t lvl, input logic [6:0] t);
		int sum;
		sum = int'(lvl) + 8 * int'(t);
		return (sum > int'(EG_MAX)) ? EG_MAX : eg_level_t'(sum);
	endfunction

	task automatic apply_reset;
		@(posedge clk);
		rst   <= 1'b1;
		keyon <= 1'b0;
		tl    <= '0;
		repeat (RESET_CYCLES) @(posedge clk);
		rst <= 1'b0;
		@(negedge clk); // first cycle out of reset
	endtask

	//////////////////////////////////////////////////
	// directed tests
	task automatic reset_state;
		apply_reset();
		check_level(eg_out, EG_MAX, "eg_out after reset");
		check_bit(pg_rst, 1'b0, "pg_rst after reset");
	endtask

	task automatic instant_attack;
		logic [6:0] t;
		draw_bits(7, t);
		@(posedge clk);
		rates <= {5'd31, 5'd0, 5'd0, 4'd0, 4'd0}; // arate rate1 rate2 rrate d1l
		keyon <= 1'b1;
		tl    <= t;
		repeat (KEY_WINDOW) @(negedge clk);
		for (int r = 0; r < 4; r++) begin
			if (r > 0) begin // fresh tl needs one cycle to reach eg_out
				draw_bits(7, t);
				@(posedge clk);
				tl <= t;
				@(negedge clk);
			end
			repeat (NUM_SLOTS) begin
				@(negedge clk);
				check_level(eg_out, total_level('0, t), "instant attack output");
				check_bit(pg_rst, 1'b0, "pg_rst once the attack is done");
			end
		end
		// level stays near 0 in a slow release so only the key-on edge can raise pg_rst
		@(posedge clk);
		keyon <= 1'b0;
		repeat (NUM_SLOTS) @(posedge clk);
		keyon <= 1'b1;
		@(posedge clk); // edge reaches pg_rst one cycle later
		repeat (NUM_SLOTS) begin
			@(negedge clk);
			check_bit(pg_rst, 1'b1, "pg_rst pulse on key-on");
		end
	endtask

	task automatic normal_attack;
		eg_level_t last [NUM_SLOTS];
		logic      at_zero [NUM_SLOTS];
		int        left;
		int        s;
		int        n;
		left = NUM_SLOTS;
		n    = 0;
		for (int i = 0; i < NUM_SLOTS; i++) begin
			last[i]    = EG_MAX;
			at_zero[i] = 1'b0;
		end
		@(posedge clk);
		rates <= {5'd28, 5'd31, 5'd0, 4'd15, 4'd6}; // rate1 fast for the sustain test
		keyon <= 1'b1;
		while (left > 0) begin
			@(negedge clk);
			s = cycles % NUM_SLOTS; // same slot every round
			if (!at_zero[s]) begin
				if (eg_out > last[s])
					check_level(eg_out, last[s], "attack level rose");
				last[s] = eg_out;
				if (eg_out == '0) begin
					at_zero[s] = 1'b1;
					left--;
				end
			end
			n++;
			if (n > ATTACK_LIMIT)
				report_error("attack did not reach zero on every slot");
		end
	endtask

	task automatic sustain_hold;
		logic settled [NUM_SLOTS];
		int   left;
		int   s;
		int   n;
		left = NUM_SLOTS;
		n    = 0;
		for (int i = 0; i < NUM_SLOTS; i++)
			settled[i] = 1'b0;
		while (left > 0) begin
			@(negedge clk);
			s = cycles % NUM_SLOTS;
			if (eg_out >= 10'd208) // d1l 6 stops decay at 192 plus one step
				report_error("decay went past the sustain level");
			if (!settled[s] && eg_out >= 10'd192) begin
				settled[s]     = 1'b1;
				sustain_lvl[s] = eg_out;
				left--;
			end
			n++;
			if (n > SUSTAIN_LIMIT)
				report_error("decay did not reach the sustain level on every slot");
		end
		repeat (8 * NUM_SLOTS) begin // spans several counter steps
			@(negedge clk);
			s = cycles % NUM_SLOTS;
			check_level(eg_out, sustain_lvl[s], "sustain level held");
		end
	endtask

	task automatic tl_saturation;
		logic [6:0] t;
		logic [6:0] spread;
		int         s;
		for (int r = 0; r < 3; r++) begin
			draw_bits(4, spread);
			t = 7'd127 - spread; // 112 to 127
			@(posedge clk);
			tl <= t;
			@(negedge clk);
			repeat (NUM_SLOTS) begin
				@(negedge clk);
				s = cycles % NUM_SLOTS;
				check_level(eg_out, total_level(sustain_lvl[s], t), "tl saturation");
			end
		end
		@(posedge clk);
		tl <= '0;
		repeat (2) @(negedge clk); // back to plain sustain
	endtask

	task automatic release_to_silence;
		eg_level_t last [NUM_SLOTS];
		logic      silent [NUM_SLOTS];
		int        left;
		int        s;
		int        n;
		left = NUM_SLOTS;
		n    = 0;
		for (int i = 0; i < NUM_SLOTS; i++) begin
			last[i]   = sustain_lvl[i];
			silent[i] = 1'b0;
		end
		@(posedge clk);
		keyon <= 1'b0; // key-off edge with rrate 15
		while (left > 0) begin
			@(negedge clk);
			s = cycles % NUM_SLOTS;
			if (eg_out < last[s])
				check_level(eg_out, last[s], "release level fell");
			last[s] = eg_out;
			if (!silent[s] && eg_out == EG_MAX) begin
				silent[s] = 1'b1;
				left--;
			end
			n++;
			if (n > RELEASE_LIMIT)
				report_error("release did not reach silence on every slot");
		end
		repeat (NUM_SLOTS) @(negedge clk); // silent levels come round to stage II
		repeat (2 * NUM_SLOTS) begin
			@(negedge clk);
			check_level(eg_out, EG_MAX, "eg_out after release");
			check_bit(pg_rst, 1'b1, "pg_rst while silent");
		end
	endtask

	//////////////////////////////////////////////////
	initial begin
		clk     = 1'b0;
		rst     = 1'b1;
		clk_en  = 1'b1; // every cycle is a slot cycle
		zero    = 1'b0;
		keyon   = 1'b0;
		rates   = '0;
		keycode = '0; // no key scaling
		ks      = '0;
		tl      = '0;
		lfsr    = 32'h2ae4c0bb;
		reset_state();
		instant_attack();
		apply_reset();
		normal_attack();
		sustain_hold();
		tl_saturation();
		release_to_silence();
		$display("all tests passed");
		$finish;
	end

endmodule

`default_nettype wire
